/* Bender.yml */
package:
  name: gpio_chaser

export_include_dirs:
  - hdl

sources:
  - include_dirs:
      - hdl
    files:
      - hdl/chaser_pkg.sv
      - hdl/chaser_ctrl_if.sv
      - hdl/chaser_step_if.sv
      - hdl/chaser_apb_regs.sv
      - hdl/chaser_tick_gen.sv
      - hdl/chaser_step_counter.sv
      - hdl/chaser_pin_decoder.sv
      - hdl/gpio_chaser.sv
  - target: test
    include_dirs:
      - hdl
    files:
      - bench/gpio_chaser_asserts.sv
      - bench/gpio_chaser_tb.sv

/* bench/gpio_chaser_asserts.sv */
//////////////////////////////////////////////////
// Bound to gpio_chaser, probes regs_inst and step_bus
// fail_count is read back by the testbench
//////////////////////////////////////////////////
`timescale 1ns/1ns
`default_nettype none

`include "chaser_defs.svh"

module gpio_chaser_asserts (
    input  wire logic                   clk,
    input  wire logic                   reset,
    input  wire chaser_pkg::apb_addr_t  paddr,
    input  wire logic                   psel,
    input  wire logic                   penable,
    input  wire logic                   pwrite,
    input  wire chaser_pkg::apb_data_t  prdata,
    input  wire logic                   pready,
    input  wire logic                   pslverr,
    input  wire chaser_pkg::pins_t      gpio_out,
    input  wire chaser_pkg::pins_t      gpio_oeb,
    input  wire logic                   done_irq,
    input  wire chaser_pkg::step_t      step,        // From step_bus
    input  wire logic                   enable_bit,  // Register internals
    input  wire logic                   stop_bit,
    input  wire chaser_pkg::presc_t     presc_reg
);

    int   fail_count = 0;
    logic access;
    logic mapped;

    assign access = psel && penable;
    assign mapped = (paddr == `CHASER_CTRL_OFS) || (paddr == `CHASER_PRESC_OFS)
                 || (paddr == `CHASER_STATUS_OFS);

    reset_values: assert property (@(posedge clk)
        reset |=> (gpio_out == '0 && gpio_oeb == '1 && !done_irq && !pslverr))
        else begin fail_count++; $error("outputs left reset with wrong values"); end

    // No wait states
    ready_in_access: assert property (@(posedge clk) disable iff (reset)
        access |-> pready)
        else begin fail_count++; $error("pready low in an access cycle"); end

    unmapped_error: assert property (@(posedge clk) disable iff (reset)
        access |-> (pslverr == !mapped) && (mapped || prdata == '0))
        else begin fail_count++; $error("pslverr or read data wrong for address"); end

    // Bad write must not touch any register
    unmapped_write_ignored: assert property (@(posedge clk) disable iff (reset)
        (access && pwrite && !mapped) |=> $stable({enable_bit, stop_bit, presc_reg}))
        else begin fail_count++; $error("write to unmapped address changed a register"); end

    pins_one_hot: assert property (@(posedge clk) disable iff (reset)
        $onehot0(gpio_out))
        else begin fail_count++; $error("more than one pin high"); end

    done_after_finish: assert property (@(posedge clk) disable iff (reset)
        $rose(done_irq) |-> $past(step) == `CHASER_STEP_LAST)
        else begin fail_count++; $error("done_irq rose before the last step"); end

    step_moves_by_one: assert property (@(posedge clk) disable iff (reset)
        (step != $past(step)) |-> (step == $past(step) + 1 || step == '0))
        else begin fail_count++; $error("step skipped a value"); end

endmodule

bind gpio_chaser gpio_chaser_asserts chaser_asserts_inst (
    .*,
    .step       (step_bus.step),
    .enable_bit (regs_inst.enable_bit),
    .stop_bit   (regs_inst.stop_bit),
    .presc_reg  (regs_inst.presc_reg)
);

`default_nettype wire

/* bench/gpio_chaser_tb.sv */
//////////////////////////////////////////////////
// Expects the small sim CHASER_CYCLES_PER_UNIT
// Prescalers kept to 1..4 for a short run
//////////////////////////////////////////////////
`timescale 1ns/1ns
`default_nettype none

`include "chaser_defs.svh"

module gpio_chaser_tb;

    localparam int                TIMEOUT  = 2000;  // Cycles for any one wait
    localparam chaser_pkg::pins_t ALL_ONES = '1;

    logic clk, reset, psel, penable, pwrite, pready, pslverr, done_irq;
    chaser_pkg::apb_addr_t paddr;
    chaser_pkg::apb_data_t pwdata, prdata;
    chaser_pkg::pins_t     gpio_out, gpio_oeb;

    integer                seed;
    int                    check_errors, timeout_errors, period, len;
    chaser_pkg::apb_data_t rd_data, wdata, presc_model;  // Own register model
    logic                  rd_err;
    chaser_pkg::pins_t     frozen;
    chaser_pkg::step_t     frozen_step;

    gpio_chaser gpio_chaser_inst (.*);

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    task automatic check_value(input string name, input logic [63:0] expected,
                               input logic [63:0] actual);
        assert (actual === expected) else begin
            check_errors++;
            $display("ERROR %s: expected 0x%0h, actual 0x%0h", name, expected, actual);
        end
    endtask

    // Entered and left on a falling edge
    task automatic bus_transfer(input chaser_pkg::apb_addr_t addr, input logic write,
                                input chaser_pkg::apb_data_t data);
        int n;
        paddr   = addr;
        pwrite  = write;
        pwdata  = data;
        psel    = 1'b1;  // Setup
        penable = 1'b0;
        @(negedge clk);
        penable = 1'b1;  // Access
        n = 0;
        do begin
            @(negedge clk);
            n++;
        end while (!pready && n < 16);
        if (!pready) begin
            timeout_errors++;
            $display("APB transfer to address 0x%0h never saw pready", addr);
        end
        rd_data = prdata;  // Still in access phase here
        rd_err  = pslverr;
        psel    = 1'b0;
        penable = 1'b0;
    endtask

    task automatic write_reg(input chaser_pkg::apb_addr_t addr, input chaser_pkg::apb_data_t data);
        bus_transfer(addr, 1'b1, data);
    endtask

    task automatic read_reg(input chaser_pkg::apb_addr_t addr, input string name,
                            input chaser_pkg::apb_data_t expected);
        bus_transfer(addr, 1'b0, '0);
        check_value(name, expected, rd_data);
    endtask

    task automatic wait_for_pins(input chaser_pkg::pins_t target, input string name);
        int n;
        n = 0;
        while (gpio_out !== target && n < TIMEOUT) begin
            @(negedge clk);
            n++;
        end
        if (gpio_out !== target) begin
            timeout_errors++;
            $display("Timed out in %s waiting for gpio_out 0x%0h", name, target);
        end
    endtask

    // Fresh random prescaler with junk in the upper bits
    task automatic load_prescaler();
        wdata       = {$random(seed)} % 4 + 1;
        wdata[31:14] = $random(seed);
        presc_model = wdata & 32'h3fff;  // Only 14 bits stored
        period      = presc_model * `CHASER_CYCLES_PER_UNIT;
        write_reg(`CHASER_PRESC_OFS, wdata);
        read_reg(`CHASER_PRESC_OFS, "presc_readback", presc_model);
    endtask

    initial begin
        seed = 13161;
        check_errors = 0;
        timeout_errors = 0;
        reset = 1'b1;
        paddr = '0;
        psel = 1'b0;
        penable = 1'b0;
        pwrite = 1'b0;
        pwdata = '0;
        repeat (3) @(negedge clk);
        reset = 1'b0;

        check_value("reset_gpio_out", '0, gpio_out);
        check_value("reset_gpio_oeb", ALL_ONES, gpio_oeb);
        check_value("reset_done_irq", 0, done_irq);
        read_reg(`CHASER_CTRL_OFS, "reset_ctrl", '0);
        load_prescaler();

        // Unmapped address, both directions
        write_reg(4'hc, 32'hffff_ffff);
        check_value("bad_write_pslverr", 1, rd_err);
        read_reg(4'hc, "bad_read_data", '0);
        check_value("bad_read_pslverr", 1, rd_err);
        read_reg(`CHASER_PRESC_OFS, "presc_after_bad_write", presc_model);

        // Full run, order and period of every pin
        write_reg(`CHASER_CTRL_OFS, 32'h1);
        read_reg(`CHASER_CTRL_OFS, "ctrl_enable", 32'h1);
        wait_for_pins(chaser_pkg::pins_t'(1), "first_pin");
        for (int pin = 0; pin < `CHASER_NUM_PINS; pin++) begin
            len = 0;
            while (gpio_out === chaser_pkg::pins_t'(1) << pin && len < TIMEOUT) begin
                @(negedge clk);
                len++;
            end
            check_value("pin_period", period, len);
            check_value("pin_order", (pin == `CHASER_NUM_PINS - 1) ? '0
                        : chaser_pkg::pins_t'(1) << (pin + 1), gpio_out);
        end
        len = 0;
        while (!done_irq && len < TIMEOUT) begin
            @(negedge clk);
            len++;
        end
        check_value("done_irq_set", 1, done_irq);
        read_reg(`CHASER_STATUS_OFS, "status_done", (`CHASER_STEP_LAST << 8) | 1);

        // Stop, then W1C on done
        write_reg(`CHASER_CTRL_OFS, 32'h3);
        read_reg(`CHASER_CTRL_OFS, "ctrl_stop", 32'h3);
        write_reg(`CHASER_STATUS_OFS, 32'h1);
        read_reg(`CHASER_STATUS_OFS, "status_cleared", '0);
        check_value("done_irq_cleared", 0, done_irq);

        // Stop in the middle of a run
        load_prescaler();
        write_reg(`CHASER_CTRL_OFS, 32'h1);
        wait_for_pins(chaser_pkg::pins_t'(1) << 1, "stop_pin");
        write_reg(`CHASER_CTRL_OFS, 32'h3);
        repeat (2) @(negedge clk);
        check_value("stop_gpio_out", '0, gpio_out);
        read_reg(`CHASER_STATUS_OFS, "stop_step", '0);

        // Pause and resume
        write_reg(`CHASER_CTRL_OFS, 32'h1);
        wait_for_pins(chaser_pkg::pins_t'(1) << 3, "pause_pin");
        write_reg(`CHASER_CTRL_OFS, 32'h0);  // Lands long before the next tick
        frozen      = chaser_pkg::pins_t'(1) << 3;
        frozen_step = 4;                     // Pin 3 is step 4
        repeat (3) @(negedge clk);
        check_value("paused_pin", frozen, gpio_out);
        repeat (50) @(negedge clk);  // Longer than any pin period
        check_value("paused_gpio_out", frozen, gpio_out);
        check_value("paused_gpio_oeb", ALL_ONES, gpio_oeb);
        read_reg(`CHASER_STATUS_OFS, "paused_step", 32'(frozen_step) << 8);
        write_reg(`CHASER_CTRL_OFS, 32'h1);
        check_value("resume_same_pin", frozen, gpio_out);
        @(negedge clk);
        check_value("resume_gpio_oeb", '0, gpio_oeb);
        wait_for_pins(frozen << 1, "resume_next_pin");

        @(negedge clk);
        $display("Check errors: %0d, timeouts: %0d, assertion failures: %0d",
                 check_errors, timeout_errors, gpio_chaser_inst.chaser_asserts_inst.fail_count);
        if (check_errors + timeout_errors + gpio_chaser_inst.chaser_asserts_inst.fail_count == 0)
            $display("Verification passed");
        else
            $display("Verification failed");
        $finish;
    end

endmodule

`default_nettype wire

/* hdl/chaser_apb_regs.sv */
//////////////////////////////////////////////////
// APB slave without wait states, pready always high
// Unmapped addresses give pslverr and read zero
//////////////////////////////////////////////////
`timescale 1ns/1ns
`default_nettype none

`include "chaser_defs.svh"

module chaser_apb_regs (
    input  wire logic                   clk,
    input  wire logic                   reset,
    input  wire chaser_pkg::apb_addr_t  paddr,
    input  wire logic                   psel,
    input  wire logic                   penable,
    input  wire logic                   pwrite,
    input  wire chaser_pkg::apb_data_t  pwdata,
    output chaser_pkg::apb_data_t       prdata,
    output logic                        pready,
    output logic                        pslverr,
    output logic                        done_irq,
    chaser_ctrl_if.regs                 ctrl,
    chaser_step_if.regs                 stat
);

    logic                enable_bit;   // CTRL bit 0
    logic                stop_bit;     // CTRL bit 1, wins over enable
    chaser_pkg::presc_t  presc_reg;
    logic                done_bit;     // Sticky STATUS bit 0

    logic access;
    logic sel_ctrl;
    logic sel_presc;
    logic sel_status;
    logic addr_hit;
    logic wr_ctrl;
    logic wr_presc;
    logic wr_status;

    // Access phase of a transfer
    assign access     = psel & penable;

    assign sel_ctrl   = (paddr == `CHASER_CTRL_OFS);
    assign sel_presc  = (paddr == `CHASER_PRESC_OFS);
    assign sel_status = (paddr == `CHASER_STATUS_OFS);
    assign addr_hit   = sel_ctrl | sel_presc | sel_status;

    // Writes land on the access-cycle edge
    assign wr_ctrl    = access & pwrite & sel_ctrl;
    assign wr_presc   = access & pwrite & sel_presc;
    assign wr_status  = access & pwrite & sel_status;

    assign pready     = access;              // Never stretched
    assign pslverr    = access & ~addr_hit;  // Bad address only

    // Control and prescaler registers
    always_ff @(posedge clk) begin
        if (reset) begin
            enable_bit <= 1'b0;
            stop_bit   <= 1'b0;
            presc_reg  <= '0;
        end else begin
            if (wr_ctrl) begin
                enable_bit <= pwdata[0];
                stop_bit   <= pwdata[1];
            end
            if (wr_presc)
                presc_reg <= pwdata[`CHASER_PRESC_W-1:0];  // Upper bits dropped
        end
    end

    // Done flag
    // Set has priority, so a clear only sticks once stop has dropped finished
    always_ff @(posedge clk) begin
        if (reset)
            done_bit <= 1'b0;
        else if (stat.finished)
            done_bit <= 1'b1;
        else if (ctrl.clear_done)
            done_bit <= 1'b0;
    end

    assign done_irq = done_bit;

    // Outputs toward the tick stage
    assign ctrl.run        = enable_bit & ~stop_bit;  // Stop wins
    assign ctrl.clear      = stop_bit;
    assign ctrl.prescaler  = presc_reg;
    assign ctrl.clear_done = wr_status & pwdata[0];   // W1C strobe

    // Read mux, valid while paddr is held in the access cycle
    always_comb begin
        prdata = '0;  // Unmapped reads return zero
        if (sel_ctrl)
            prdata = chaser_pkg::apb_data_t'({stop_bit, enable_bit});
        else if (sel_presc)
            prdata = chaser_pkg::apb_data_t'(presc_reg);
        else if (sel_status) begin
            prdata[0] = done_bit;
            prdata[8 +: `CHASER_STEP_W] = stat.step;  // Bits 13:8
        end
    end

endmodule

`default_nettype wire

/* hdl/chaser_ctrl_if.sv */
//////////////////////////////////////////////////
// Control from the register block to the tick stage
// clear_done is a single-cycle strobe
//////////////////////////////////////////////////
`timescale 1ns/1ns
`default_nettype none

interface chaser_ctrl_if;

    logic                 run;         // Enable and not stop
    logic                 clear;       // Stop bit, zeroes counters
    chaser_pkg::presc_t   prescaler;   // Pin period in units
    logic                 clear_done;  // W1C strobe on STATUS bit 0

    // Register side drives everything
    modport regs (
        output run,
        output clear,
        output prescaler,
        output clear_done
    );

    // Tick stage only listens
    modport tick (
        input  run,
        input  clear,
        input  prescaler,
        input  clear_done
    );

endinterface

`default_nettype wire

/* hdl/chaser_defs.svh */
//////////////////////////////////////////////////
// Edit CHASER_CYCLES_PER_UNIT to 10000 for silicon
// Offsets assume 32-bit word aligned registers
//////////////////////////////////////////////////
`ifndef CHASER_DEFS_SVH
`define CHASER_DEFS_SVH

`define CHASER_NUM_PINS         34     // Chased GPIO pins
`define CHASER_STEP_LAST        35     // Finished step, no pin lit
`define CHASER_CYCLES_PER_UNIT  10     // Clocks per prescaler unit, small for sim

// Field and bus widths
`define CHASER_PRESC_W          14
`define CHASER_STEP_W           6
`define CHASER_DIV_W            28     // Holds 16383 * 10000
`define CHASER_ADDR_W           4
`define CHASER_DATA_W           32

// Register byte offsets
`define CHASER_CTRL_OFS         4'h0
`define CHASER_PRESC_OFS        4'h4
`define CHASER_STATUS_OFS       4'h8

`endif

/* hdl/chaser_pin_decoder.sv */
//////////////////////////////////////////////////
// gpio_out lags step by one cycle
// gpio_oeb is active low, driven only while running
//////////////////////////////////////////////////
`timescale 1ns/1ns
`default_nettype none

`include "chaser_defs.svh"

module chaser_pin_decoder (
    input  wire logic       clk,
    input  wire logic       reset,
    input  wire logic       run,
    chaser_step_if.decoder  stp,
    output chaser_pkg::pins_t gpio_out,
    output chaser_pkg::pins_t gpio_oeb
);

    chaser_pkg::pins_t pins_next;

    // One-hot decode, idle and finished light nothing
    always_comb begin
        pins_next = '0;
        if (stp.step != '0 && stp.step != chaser_pkg::step_t'(`CHASER_STEP_LAST))
            pins_next = chaser_pkg::pins_t'(1) << (stp.step - chaser_pkg::step_t'(1));
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            gpio_out <= '0;
            gpio_oeb <= '1;      // All pins released
        end else begin
            gpio_out <= pins_next;
            gpio_oeb <= run ? '0 : '1;  // Frozen pin floats while paused
        end
    end

endmodule

`default_nettype wire

/* hdl/chaser_pkg.sv */
//////////////////////////////////////////////////
// Widths come from chaser_defs.svh
//////////////////////////////////////////////////
`default_nettype none

`include "chaser_defs.svh"

package chaser_pkg;

    // Prescaler value in units of CHASER_CYCLES_PER_UNIT clocks
    typedef logic [`CHASER_PRESC_W-1:0] presc_t;

    // Sequence step
    // 0 idle, 1 to 34 light pin step-1, 35 finished
    typedef logic [`CHASER_STEP_W-1:0] step_t;

    // One bit per chased pin
    typedef logic [`CHASER_NUM_PINS-1:0] pins_t;

    // APB address and data
    typedef logic [`CHASER_ADDR_W-1:0] apb_addr_t;
    typedef logic [`CHASER_DATA_W-1:0] apb_data_t;

    // Tick divider count, wide enough for full prescaler on silicon
    typedef logic [`CHASER_DIV_W-1:0] div_cnt_t;

endpackage

`default_nettype wire

/* hdl/chaser_step_counter.sv */
//////////////////////////////////////////////////
// Runs once from idle to the finished step
// Only clear brings it back to idle
//////////////////////////////////////////////////
`timescale 1ns/1ns
`default_nettype none

`include "chaser_defs.svh"

module chaser_step_counter (
    input  wire logic      clk,
    input  wire logic      reset,
    input  wire logic      clear,
    chaser_step_if.counter stp
);

    localparam chaser_pkg::step_t STEP_IDLE = '0;
    localparam chaser_pkg::step_t STEP_LAST = chaser_pkg::step_t'(`CHASER_STEP_LAST);

    chaser_pkg::step_t step_q;
    logic              at_last;

    assign at_last = (step_q == STEP_LAST);

    // Advance one step per tick, saturate at the end
    always_ff @(posedge clk) begin
        if (reset) begin
            step_q <= STEP_IDLE;
        end else if (clear) begin
            step_q <= STEP_IDLE;   // Stop returns to idle
        end else if (stp.tick && !at_last) begin
            step_q <= step_q + chaser_pkg::step_t'(1);
        end
    end

    assign stp.step     = step_q;
    assign stp.finished = at_last;  // Level, held until clear

endmodule

`default_nettype wire

/* hdl/chaser_step_if.sv */
//////////////////////////////////////////////////
// Strobes and step between the pipeline stages
// No back-pressure, tick is one cycle wide
//////////////////////////////////////////////////
`timescale 1ns/1ns
`default_nettype none

interface chaser_step_if;

    logic                 tick;      // One pulse per pin period
    chaser_pkg::step_t    step;      // Current sequence step
    logic                 finished;  // Step has reached the last value

    modport tick_gen (output tick);   // Tick generator

    modport counter (             // Step counter
        input  tick,
        output step,
        output finished
    );

    modport decoder (input step);  // Pin decoder

    modport regs (                // Status readback and done flag
        input  step,
        input  finished
    );

endinterface

`default_nettype wire

/* hdl/chaser_tick_gen.sv */
//////////////////////////////////////////////////
// Prescaler of zero gives no ticks
// Count pauses while run is low
//////////////////////////////////////////////////
`timescale 1ns/1ns
`default_nettype none

`include "chaser_defs.svh"

module chaser_tick_gen (
    input  wire logic       clk,
    input  wire logic       reset,
    chaser_ctrl_if.tick     ctrl,
    chaser_step_if.tick_gen stp
);

    chaser_pkg::div_cnt_t div_cnt;     // Clocks into current period
    chaser_pkg::div_cnt_t div_limit;   // Clocks per pin period
    logic                 counting;
    logic                 wrap;

    // Period length in clocks
    assign div_limit = chaser_pkg::div_cnt_t'(ctrl.prescaler)
                     * chaser_pkg::div_cnt_t'(`CHASER_CYCLES_PER_UNIT);

    assign counting = ctrl.run && (ctrl.prescaler != '0);

    // Last clock of the period, >= covers a prescaler lowered mid count
    assign wrap = (div_cnt >= div_limit - chaser_pkg::div_cnt_t'(1));

    always_ff @(posedge clk) begin
        if (reset) begin
            div_cnt  <= '0;
            stp.tick <= 1'b0;
        end else if (ctrl.clear) begin
            div_cnt  <= '0;     // Stop restarts the period
            stp.tick <= 1'b0;
        end else if (counting) begin
            if (wrap) begin
                div_cnt  <= '0;
                stp.tick <= 1'b1;  // One cycle pulse
            end else begin
                div_cnt  <= div_cnt + chaser_pkg::div_cnt_t'(1);
                stp.tick <= 1'b0;
            end
        end else begin
            stp.tick <= 1'b0;   // Paused, keep div_cnt
        end
    end

endmodule

`default_nettype wire

/* hdl/gpio_chaser.sv */
//////////////////////////////////////////////////
// One pin high at a time, 34 pins, then done_irq
// Enable, stop and prescaler set over APB
//////////////////////////////////////////////////
`timescale 1ns/1ns
`default_nettype none

module gpio_chaser (
    input  wire logic                   clk,
    input  wire logic                   reset,
    input  wire chaser_pkg::apb_addr_t  paddr,
    input  wire logic                   psel,
    input  wire logic                   penable,
    input  wire logic                   pwrite,
    input  wire chaser_pkg::apb_data_t  pwdata,
    output chaser_pkg::apb_data_t       prdata,
    output logic                        pready,
    output logic                        pslverr,
    output chaser_pkg::pins_t           gpio_out,
    output chaser_pkg::pins_t           gpio_oeb,
    output logic                        done_irq
);

    chaser_ctrl_if ctrl_bus ();   // Registers to tick stage
    chaser_step_if step_bus ();   // Stage to stage strobes

    // APB registers, done flag
    chaser_apb_regs regs_inst (
        .clk      (clk),
        .reset    (reset),
        .paddr    (paddr),
        .psel     (psel),
        .penable  (penable),
        .pwrite   (pwrite),
        .pwdata   (pwdata),
        .prdata   (prdata),
        .pready   (pready),
        .pslverr  (pslverr),
        .done_irq (done_irq),
        .ctrl     (ctrl_bus.regs),
        .stat     (step_bus.regs)
    );

    // Stage 1, pin period ticks
    chaser_tick_gen tick_inst (
        .clk   (clk),
        .reset (reset),
        .ctrl  (ctrl_bus.tick),
        .stp   (step_bus.tick_gen)
    );

    // Stage 2, step 0 to 35
    chaser_step_counter step_inst (
        .clk   (clk),
        .reset (reset),
        .clear (ctrl_bus.clear),
        .stp   (step_bus.counter)
    );

    // Stage 3, pins
    chaser_pin_decoder dec_inst (
        .clk      (clk),
        .reset    (reset),
        .run      (ctrl_bus.run),
        .stp      (step_bus.decoder),
        .gpio_out (gpio_out),
        .gpio_oeb (gpio_oeb)
    );

endmodule

`default_nettype wire

/* vlog.f */
+incdir+hdl
hdl/chaser_pkg.sv
hdl/chaser_ctrl_if.sv
hdl/chaser_step_if.sv
hdl/chaser_apb_regs.sv
hdl/chaser_tick_gen.sv
hdl/chaser_step_counter.sv
hdl/chaser_pin_decoder.sv
hdl/gpio_chaser.sv
bench/gpio_chaser_asserts.sv
bench/gpio_chaser_tb.sv
